// File: Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert
TOP      := tb_motor_board
FILELIST := project.f
OBJ_DIR  := obj_dir
LOG      := sim.log
FAIL_MSG := FAIL: see errors above
PASS_MSG := PASS: all tests

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with $(SIM), run it, check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation ended early"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: project.f
+incdir+verilog
verilog/motor_board_pkg.sv
verilog/host_arbiter.sv
verilog/dac_cmd_regs.sv
verilog/adc_feedback.sv
verilog/safety_monitor.sv
verilog/motor_board_top.sv
test/motor_board_chk.sv
test/tb_motor_board.sv

// File: test/motor_board_chk.sv
`timescale 1ns/1ps

module motor_board_chk import motor_board_pkg::*; (
    input logic     sysclk,
    input logic     arst_n,
    input logic     fw_req_ready,
    input logic     eth_req_ready,
    input bus_rsp_t fw_rsp,
    input logic     fw_rsp_valid,
    input logic     fw_rsp_ready,
    input bus_rsp_t eth_rsp,
    input logic     eth_rsp_valid,
    input logic     eth_rsp_ready
);
    logic rsp_pend;

    assign rsp_pend = fw_rsp_valid | eth_rsp_valid;   // either port waiting

    // ----------------------------------------
    // back-pressure and response hold
    // ----------------------------------------
    a_no_req_while_pend: assert property (@(posedge sysclk) disable iff (!arst_n)
        rsp_pend |-> !fw_req_ready && !eth_req_ready)
        else $error("req_ready high while a response is pending");

    a_fw_rsp_hold: assert property (@(posedge sysclk) disable iff (!arst_n)
        fw_rsp_valid && !fw_rsp_ready |=> fw_rsp_valid && $stable(fw_rsp))
        else $error("fw response changed or dropped before acceptance");

    a_eth_rsp_hold: assert property (@(posedge sysclk) disable iff (!arst_n)
        eth_rsp_valid && !eth_rsp_ready |=> eth_rsp_valid && $stable(eth_rsp))
        else $error("eth response changed or dropped before acceptance");

    // one owner for the shared response register
    a_one_rsp: assert property (@(posedge sysclk) disable iff (!arst_n)
        !(fw_rsp_valid && eth_rsp_valid))
        else $error("fw and eth responses valid together");

endmodule

bind motor_board_top motor_board_chk u_chk (
    .sysclk, .arst_n,
    .fw_req_ready, .eth_req_ready,
    .fw_rsp, .fw_rsp_valid, .fw_rsp_ready,
    .eth_rsp, .eth_rsp_valid, .eth_rsp_ready
);

// File: test/motor_board_vectors.txt
// op sel addr data exp_a exp_b, hex, one operation per line, exp is {err, rdata}
// op 1 write, 2 read, 3 read with rsp_ready stalled, 4 eth reads addr and fw reads data
// at once, 5 adc sample to axis sel, 6 expect amp_enable, f end; sel 0 fw, 1 eth
1 0 0011 00001234 000000000 0
1 0 0021 00008100 000000000 0
1 0 0031 0000a5a5 000000000 0
1 0 0041 00007f00 000000000 0
2 1 0011 00000000 000001234 0
2 1 0021 00000000 000008100 0
2 1 0031 00000000 00000a5a5 0
2 1 0041 00000000 000007f00 0
5 1 0000 00008010 0 0
5 3 0000 00008020 0 0
5 4 0000 00007ff0 0 0
5 1 0000 00008040 0 0
2 1 0010 00000000 000008040 0
2 1 0030 00000000 000008020 0
2 1 0040 00000000 000007ff0 0
4 0 0030 00000021 000008020 000008100
3 1 0011 00000000 000001234 0
3 0 0040 00000000 000007ff0 0
1 1 0000 0000000f 000000000 0
6 0 0000 00000000 f 0
5 2 0000 00008500 0 0
5 2 0000 00008500 0 0
5 2 0000 00008100 0 0
6 0 0000 00000000 f 0
5 2 0000 00008500 0 0
5 2 0000 00008500 0 0
5 2 0000 00008500 0 0
6 0 0000 00000000 d 0
2 0 0000 00000000 00000020d 0
1 0 0000 0000000f 000000000 0
6 0 0000 00000000 f 0
2 1 0000 00000000 00000000f 0
2 1 0052 00000000 100000000 0
f 0 0000 00000000 0 0

// File: test/tb_motor_board.sv
`timescale 1ns/1ps

`include "motor_board_settings.svh"

module tb_motor_board import motor_board_pkg::*; ();

    localparam int VEC_W       = 6;     // words per vector line
    localparam int MAX_VEC     = 64;
    localparam int CYC_PER_VEC = 20;    // timeout budget per vector

    logic                    sysclk = 1'b0;
    logic                    arst_n;
    bus_req_t                fw_req;
    logic                    fw_req_valid;
    logic                    fw_req_ready;
    bus_rsp_t                fw_rsp;
    logic                    fw_rsp_valid;
    logic                    fw_rsp_ready;
    bus_req_t                eth_req;
    logic                    eth_req_valid;
    logic                    eth_req_ready;
    bus_rsp_t                eth_rsp;
    logic                    eth_rsp_valid;
    logic                    eth_rsp_ready;
    adc_sample_t             sample;
    logic                    sample_valid;
    logic [`MB_NUM_AXES-1:0] amp_enable;

    logic [35:0]             vec_mem [0:VEC_W*MAX_VEC-1];
    logic [31:0]             lfsr_q;
    int                      cycle_cnt   = 0;
    int                      timeout_lim = 0;   // set once the vectors are counted
    int                      n_vec;
    bus_req_t                req_a;             // a side is eth in the dual case
    bus_req_t                req_b;
    bus_rsp_t                got_a;
    bus_rsp_t                got_b;
    int                      t_a;
    int                      t_b;

    motor_board_top u_dut (.*);

    always #20 sysclk = ~sysclk;    // 40 ns period

    // ----------------------------------------
    // error stop, compares, lfsr
    // ----------------------------------------
    task automatic stop_with_error(input string what);
        $display("%s", what);
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    task automatic check_rsp(input string name, input bus_rsp_t got, input bus_rsp_t exp);
        if (got !== exp)
            stop_with_error($sformatf("Mismatch %s: got rdata %h err %h, expected rdata %h err %h",
                                      name, got.rdata, got.err, exp.rdata, exp.err));
    endtask

    task automatic check_amp(input logic [`MB_NUM_AXES-1:0] got,
                             input logic [`MB_NUM_AXES-1:0] exp);
        if (got !== exp)
            stop_with_error($sformatf("Mismatch amp_enable: got %h expected %h", got, exp));
    endtask

    // galois form, x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0])
            return (s >> 1) ^ 32'h8020_0003;
        return s >> 1;
    endfunction

    task automatic rand_bits(input int n, output int v);
        int i;
        v = 0;
        for (i = 0; i < n; i++) begin
            lfsr_q = lfsr_next(lfsr_q);     // one step per bit
            v = (v << 1) | int'(lfsr_q[0]);
        end
    endtask

    // file word is {err, rdata}
    function automatic bus_rsp_t to_rsp(input logic [35:0] w);
        bus_rsp_t r;
        r.rdata = w[31:0];
        r.err   = w[32];
        return r;
    endfunction

    // ----------------------------------------
    // bus and adc drivers
    // ----------------------------------------
    // one request on one port; stall > 0 holds rsp_ready low that many cycles
    task automatic host_xfer(input logic is_eth, input bus_req_t req, input int stall,
                             output bus_rsp_t rsp, output int t_rsp);
        logic     seen;
        bus_rsp_t held;
        string    name;
        int       i;
        name = is_eth ? "eth_rsp" : "fw_rsp";
        @(posedge sysclk);
        if (is_eth) begin
            eth_req       <= req;
            eth_req_valid <= 1'b1;
            if (stall > 0)
                eth_rsp_ready <= 1'b0;
        end else begin
            fw_req       <= req;
            fw_req_valid <= 1'b1;
            if (stall > 0)
                fw_rsp_ready <= 1'b0;
        end
        seen = 1'b0;
        while (!seen) begin
            @(negedge sysclk);
            seen = is_eth ? eth_req_ready : fw_req_ready;
            @(posedge sysclk);                  // accepted here when seen
        end
        if (is_eth)
            eth_req_valid <= 1'b0;
        else
            fw_req_valid <= 1'b0;
        seen = 1'b0;
        while (!seen) begin
            @(negedge sysclk);
            seen = is_eth ? eth_rsp_valid : fw_rsp_valid;
            if (!seen)
                @(posedge sysclk);
        end
        rsp   = is_eth ? eth_rsp : fw_rsp;
        t_rsp = cycle_cnt;
        for (i = 0; i < stall; i++) begin
            @(posedge sysclk);
            @(negedge sysclk);
            held = is_eth ? eth_rsp : fw_rsp;
            check_rsp(name, held, rsp);         // must not move while stalled
            if (!(is_eth ? eth_rsp_valid : fw_rsp_valid))
                stop_with_error("response valid dropped before the host accepted it");
            if (fw_req_ready || eth_req_ready)
                stop_with_error("request port ready while a response is still pending");
        end
        if (stall > 0) begin
            @(posedge sysclk);
            if (is_eth)
                eth_rsp_ready <= 1'b1;
            else
                fw_rsp_ready <= 1'b1;
        end
        @(posedge sysclk);      // response taken on this edge
    endtask

    task automatic drive_sample(input logic [2:0] axis, input logic [`MB_SAMPLE_W-1:0] value);
        @(posedge sysclk);
        sample       <= '{axis: axis, value: value};
        sample_valid <= 1'b1;
        @(posedge sysclk);
        sample_valid <= 1'b0;   // single beat
    endtask

    // timeout watchdog
    always @(posedge sysclk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (timeout_lim > 0 && cycle_cnt >= timeout_lim)
            stop_with_error($sformatf("timeout, run still busy after %0d cycles", cycle_cnt));
    end

    // ----------------------------------------
    // main sequence
    // ----------------------------------------
    initial begin
        int          vi;
        int          base;
        int          stall;
        logic [3:0]  op;
        logic [3:0]  sel;
        logic [15:0] addr;
        logic [31:0] data;
        logic [35:0] exp_a;
        logic [35:0] exp_b;
        arst_n        = 1'b0;
        fw_req        = '0;
        fw_req_valid  = 1'b0;
        fw_rsp_ready  = 1'b1;
        eth_req       = '0;
        eth_req_valid = 1'b0;
        eth_rsp_ready = 1'b1;
        sample        = '0;
        sample_valid  = 1'b0;
        lfsr_q        = 32'h59cf;
        $readmemh("test/motor_board_vectors.txt", vec_mem);
        n_vec = 0;
        while (n_vec < MAX_VEC && vec_mem[n_vec*VEC_W] !== 36'hf)
            n_vec++;
        timeout_lim = n_vec * CYC_PER_VEC;
        repeat (4) @(posedge sysclk);
        arst_n <= 1'b1;
        for (vi = 0; vi < n_vec; vi++) begin
            base  = vi * VEC_W;
            op    = vec_mem[base][3:0];
            sel   = vec_mem[base+1][3:0];
            addr  = vec_mem[base+2][15:0];
            data  = vec_mem[base+3][31:0];
            exp_a = vec_mem[base+4];
            exp_b = vec_mem[base+5];
            case (op)
                4'h1, 4'h2, 4'h3: begin
                    stall = 0;
                    if (op == 4'h3) begin
                        rand_bits(3, stall);
                        stall = stall + 1;      // 1..8 cycles
                    end
                    req_a = '{wr: (op == 4'h1), addr: addr, wdata: (op == 4'h1) ? data : '0};
                    host_xfer(sel[0], req_a, stall, got_a, t_a);
                    check_rsp(sel[0] ? "eth_rsp" : "fw_rsp", got_a, to_rsp(exp_a));
                end
                4'h4: begin
                    req_a = '{wr: 1'b0, addr: addr, wdata: '0};
                    req_b = '{wr: 1'b0, addr: data[15:0], wdata: '0};
                    fork
                        host_xfer(1'b1, req_a, 0, got_a, t_a);
                        host_xfer(1'b0, req_b, 0, got_b, t_b);
                    join
                    check_rsp("eth_rsp", got_a, to_rsp(exp_a));
                    check_rsp("fw_rsp", got_b, to_rsp(exp_b));
                    if (t_a >= t_b)
                        stop_with_error("fw response arrived before the eth response");
                end
                4'h5: drive_sample(sel[2:0], data[`MB_SAMPLE_W-1:0]);
                4'h6: begin
                    // trip shows two cycles after the capture edge
                    repeat (2) @(posedge sysclk);
                    @(negedge sysclk);
                    check_amp(amp_enable, exp_a[`MB_NUM_AXES-1:0]);
                end
                default: stop_with_error($sformatf("vector %0d has unknown op %h", vi, op));
            endcase
        end
        $display("PASS: all tests");
        $finish;
    end

endmodule

// File: verilog/adc_feedback.sv
`timescale 1ns/1ps

`include "motor_board_settings.svh"

module adc_feedback import motor_board_pkg::*; (
    input  logic        sysclk,
    input  logic        arst_n,
    input  adc_sample_t sample,
    input  logic        sample_valid,   // converter cannot stall, no ready
    output axis_words_t fb,
    output mag_evt_t    mag_evt
);
    localparam int AX_W = $clog2(`MB_NUM_AXES);

    logic                    hit;
    logic [AX_W-1:0]         ax;
    logic                    new_q;     // fb just updated
    logic [AX_W-1:0]         new_ax_q;
    logic                    evt_q;
    logic [2:0]              evt_ax_q;
    logic [`MB_SAMPLE_W-1:0] evt_mag_q;

    // axis 0 and 5..7 dropped
    assign hit = sample_valid && (sample.axis != 3'd0) && (sample.axis <= 3'(`MB_NUM_AXES));
    assign ax  = AX_W'(sample.axis - 3'd1);

    // ----------------------------------------
    // stage 1, capture
    // ----------------------------------------
    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            new_q <= 1'b0;
            for (int i = 0; i < `MB_NUM_AXES; i++)
                fb[i] <= `MB_MIDSCALE;
        end else begin
            new_q <= hit;
            if (hit)
                fb[ax] <= sample.value;
        end
    end

    always_ff @(posedge sysclk)
        if (hit)
            new_ax_q <= ax;

    // stage 2, magnitude event one cycle after capture
    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n)
            evt_q <= 1'b0;
        else
            evt_q <= new_q;
    end

    always_ff @(posedge sysclk) begin
        evt_ax_q  <= 3'(new_ax_q) + 3'd1;   // back to axis number
        evt_mag_q <= mid_dist(fb[new_ax_q]);
    end

    assign mag_evt = '{update: evt_q, axis: evt_ax_q, mag: evt_mag_q};

endmodule

// File: verilog/dac_cmd_regs.sv
`timescale 1ns/1ps

`include "motor_board_settings.svh"

module dac_cmd_regs import motor_board_pkg::*; (
    input  logic        sysclk,
    input  logic        arst_n,
    input  bus_wr_t     bus_wr,
    output axis_words_t cmd,        // current command per axis
    output axis_words_t cmd_mag     // |cmd - midscale|, one cycle behind
);
    logic [`MB_NUM_AXES-1:0] wr_hit;
    logic                    page0;

    // ----------------------------------------
    // write decode, offset 1 on chan 1..4
    // ----------------------------------------
    assign page0 = (bus_wr.addr[`MB_ADDR_W-1:8] == '0);

    always_comb begin
        for (int i = 0; i < `MB_NUM_AXES; i++) begin
            wr_hit[i] = bus_wr.en && page0
                        && (bus_wr.addr[7:4] == 4'(i + 1))
                        && (bus_wr.addr[3:0] == `MB_OFF_DAC_CTRL);
        end
    end

    // command registers, zero current out of reset
    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `MB_NUM_AXES; i++)
                cmd[i] <= `MB_MIDSCALE;
        end else begin
            for (int i = 0; i < `MB_NUM_AXES; i++) begin
                if (wr_hit[i])
                    cmd[i] <= bus_wr.data[`MB_SAMPLE_W-1:0];    // low half only
            end
        end
    end

    // ----------------------------------------
    // magnitude for the safety check
    // ----------------------------------------
    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            cmd_mag <= '0;      // matches midscale command
        end else begin
            for (int i = 0; i < `MB_NUM_AXES; i++)
                cmd_mag[i] <= mid_dist(cmd[i]);
        end
    end

endmodule

// File: verilog/host_arbiter.sv
`timescale 1ns/1ps

`include "motor_board_settings.svh"

module host_arbiter import motor_board_pkg::*; (
    input  logic          sysclk,
    input  logic          arst_n,
    // firewire master
    input  bus_req_t      fw_req,
    input  logic          fw_req_valid,
    output logic          fw_req_ready,
    output bus_rsp_t      fw_rsp,
    output logic          fw_rsp_valid,
    input  logic          fw_rsp_ready,
    // ethernet master
    input  bus_req_t      eth_req,
    input  logic          eth_req_valid,
    output logic          eth_req_ready,
    output bus_rsp_t      eth_rsp,
    output logic          eth_rsp_valid,
    input  logic          eth_rsp_ready,
    // register side
    output bus_wr_t       bus_wr,
    input  axis_words_t   cmd,
    input  axis_words_t   fb,
    input  board_status_t status
);
    localparam int AX_W = $clog2(`MB_NUM_AXES);

    logic            idle;
    logic            eth_go;
    logic            fw_go;
    logic            exec_q;        // granted request sits on the bus
    logic            exec_eth_q;    // owner of the granted request
    bus_req_t        req_q;
    logic            rsp_pend_q;
    logic            rsp_eth_q;
    bus_rsp_t        rsp_q;
    bus_rsp_t        rsp_d;
    logic            rsp_fire;
    logic [3:0]      chan;
    logic [3:0]      off;
    logic [AX_W-1:0] ax;
    logic            axis_hit;
    logic            board_hit;

    // ----------------------------------------
    // grant, eth wins a tie
    // ----------------------------------------
    assign idle          = ~exec_q & ~rsp_pend_q;    // one transaction at a time
    assign eth_req_ready = idle;
    assign fw_req_ready  = idle & ~eth_req_valid;
    assign eth_go        = eth_req_valid & eth_req_ready;
    assign fw_go         = fw_req_valid & fw_req_ready;

    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            exec_q     <= 1'b0;
            exec_eth_q <= 1'b0;
        end else begin
            exec_q <= eth_go | fw_go;   // exactly one cycle, idle drops meanwhile
            if (eth_go | fw_go)
                exec_eth_q <= eth_go;
        end
    end

    always_ff @(posedge sysclk) begin
        if (eth_go)
            req_q <= eth_req;
        else if (fw_go)
            req_q <= fw_req;
    end

    // write broadcast lands at the edge after the grant
    assign bus_wr = '{en: exec_q & req_q.wr, addr: req_q.addr, data: req_q.wdata};

    // ----------------------------------------
    // read decode
    // ----------------------------------------
    assign chan      = req_q.addr[7:4];
    assign off       = req_q.addr[3:0];
    assign ax        = AX_W'(chan - 4'd1);   // chan 1 is index 0
    assign axis_hit  = (req_q.addr[`MB_ADDR_W-1:8] == '0) && (chan != `MB_CHAN_BOARD)
                       && (chan <= 4'(`MB_NUM_AXES));
    assign board_hit = (req_q.addr[`MB_ADDR_W-1:8] == '0) && (chan == `MB_CHAN_BOARD);

    always_comb begin
        rsp_d = '{rdata: '0, err: 1'b1};   // default is unmapped
        if (axis_hit && off == `MB_OFF_ADC_DATA) begin
            rsp_d.rdata[`MB_SAMPLE_W-1:0] = fb[ax];     // current feedback, low half
            rsp_d.err = 1'b0;
        end else if (axis_hit && off == `MB_OFF_DAC_CTRL) begin
            rsp_d.rdata[`MB_SAMPLE_W-1:0] = cmd[ax];
            rsp_d.err = 1'b0;
        end else if (board_hit && off == `MB_OFF_ADC_DATA) begin
            rsp_d.rdata[`MB_NUM_AXES-1:0] = status.amp_en;
            rsp_d.rdata[8 +: `MB_NUM_AXES] = status.safety_dis;
            rsp_d.err = 1'b0;
        end
        if (req_q.wr)
            rsp_d.rdata = '0;   // write ack carries no data
    end

    // ----------------------------------------
    // response hold until accepted
    // ----------------------------------------
    assign rsp_fire = (fw_rsp_valid & fw_rsp_ready) | (eth_rsp_valid & eth_rsp_ready);

    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            rsp_pend_q <= 1'b0;
            rsp_eth_q  <= 1'b0;
        end else if (exec_q) begin
            rsp_pend_q <= 1'b1;
            rsp_eth_q  <= exec_eth_q;
        end else if (rsp_fire) begin
            rsp_pend_q <= 1'b0;
        end
    end

    always_ff @(posedge sysclk) begin
        if (exec_q)
            rsp_q <= rsp_d;     // read data taken here
    end

    assign fw_rsp        = rsp_q;
    assign eth_rsp       = rsp_q;
    assign fw_rsp_valid  = rsp_pend_q & ~rsp_eth_q;
    assign eth_rsp_valid = rsp_pend_q & rsp_eth_q;

endmodule

// File: verilog/motor_board_pkg.sv
`include "motor_board_settings.svh"

package motor_board_pkg;

    // host request, one per master
    typedef struct packed {
        logic                   wr;         // 1 = write
        logic [`MB_ADDR_W-1:0]  addr;
        logic [`MB_DATA_W-1:0]  wdata;
    } bus_req_t;

    // host response
    typedef struct packed {
        logic [`MB_DATA_W-1:0]  rdata;
        logic                   err;        // unmapped address
    } bus_rsp_t;

    // write broadcast to the register blocks, valid for one cycle
    typedef struct packed {
        logic                   en;
        logic [`MB_ADDR_W-1:0]  addr;
        logic [`MB_DATA_W-1:0]  data;
    } bus_wr_t;

    typedef struct packed {
        logic [2:0]             axis;       // 1..4 valid
        logic [`MB_SAMPLE_W-1:0] value;
    } adc_sample_t;

    // index 0 is axis 1
    typedef logic [`MB_NUM_AXES-1:0][`MB_SAMPLE_W-1:0] axis_words_t;

    typedef struct packed {
        logic                   update;     // one cycle strobe
        logic [2:0]             axis;
        logic [`MB_SAMPLE_W-1:0] mag;
    } mag_evt_t;

    typedef struct packed {
        logic [`MB_NUM_AXES-1:0] amp_en;     // enable after safety masking
        logic [`MB_NUM_AXES-1:0] safety_dis; // latched safety disables
    } board_status_t;

    // distance of an offset binary value from zero current
    function automatic logic [`MB_SAMPLE_W-1:0] mid_dist(input logic [`MB_SAMPLE_W-1:0] v);
        logic [`MB_SAMPLE_W-1:0] d;
        if (v >= `MB_MIDSCALE)
            d = v - `MB_MIDSCALE;
        else
            d = `MB_MIDSCALE - v;
        return d;
    endfunction

endpackage

// File: verilog/motor_board_settings.svh
`ifndef MOTOR_BOARD_SETTINGS_SVH
`define MOTOR_BOARD_SETTINGS_SVH

// ----------------------------------------
// board geometry
// ----------------------------------------
`define MB_NUM_AXES         4           // axes 1..4, channel 0 is the board
`define MB_ADDR_W           16
`define MB_DATA_W           32
`define MB_SAMPLE_W         16          // dac command and adc sample width

// offset binary, so zero current sits at midscale
`define MB_MIDSCALE         16'h8000

// ----------------------------------------
// safety check
// ----------------------------------------
`define MB_SAFETY_MARGIN    16'h0100    // added to 2 x |cmd|
`define MB_SAFETY_COUNT     3           // consecutive over-limit samples to trip

// ----------------------------------------
// address map, chan in addr[7:4], offset in addr[3:0]
// ----------------------------------------
`define MB_OFF_ADC_DATA     4'd0
`define MB_OFF_DAC_CTRL     4'd1
`define MB_CHAN_BOARD       4'd0

`endif

// File: verilog/motor_board_top.sv
`timescale 1ns/1ps

`include "motor_board_settings.svh"

module motor_board_top import motor_board_pkg::*; (
    input  logic                    sysclk,
    input  logic                    arst_n,
    // firewire master
    input  bus_req_t                fw_req,
    input  logic                    fw_req_valid,
    output logic                    fw_req_ready,
    output bus_rsp_t                fw_rsp,
    output logic                    fw_rsp_valid,
    input  logic                    fw_rsp_ready,
    // ethernet master
    input  bus_req_t                eth_req,
    input  logic                    eth_req_valid,
    output logic                    eth_req_ready,
    output bus_rsp_t                eth_rsp,
    output logic                    eth_rsp_valid,
    input  logic                    eth_rsp_ready,
    // adc stream and amplifier enables
    input  adc_sample_t             sample,
    input  logic                    sample_valid,
    output logic [`MB_NUM_AXES-1:0] amp_enable
);
    bus_wr_t       bus_wr;     // write broadcast
    axis_words_t   cmd;
    axis_words_t   cmd_mag;
    axis_words_t   fb;
    mag_evt_t      mag_evt;
    board_status_t status;     // channel 0 word

    // ----------------------------------------
    // register bus
    // ----------------------------------------
    host_arbiter u_arb (
        .sysclk, .arst_n,
        .fw_req, .fw_req_valid, .fw_req_ready,
        .fw_rsp, .fw_rsp_valid, .fw_rsp_ready,
        .eth_req, .eth_req_valid, .eth_req_ready,
        .eth_rsp, .eth_rsp_valid, .eth_rsp_ready,
        .bus_wr, .cmd, .fb, .status
    );

    // command and feedback side by side
    dac_cmd_regs u_dac (.sysclk, .arst_n, .bus_wr, .cmd, .cmd_mag);

    adc_feedback u_adc (.sysclk, .arst_n, .sample, .sample_valid, .fb, .mag_evt);

    // ----------------------------------------
    // safety check, combines both magnitudes
    // ----------------------------------------
    safety_monitor u_safety (
        .sysclk, .arst_n, .bus_wr, .cmd_mag, .mag_evt,
        .status, .amp_enable
    );

endmodule

// File: verilog/safety_monitor.sv
`timescale 1ns/1ps

`include "motor_board_settings.svh"

module safety_monitor import motor_board_pkg::*; (
    input  logic                    sysclk,
    input  logic                    arst_n,
    input  bus_wr_t                 bus_wr,
    input  axis_words_t             cmd_mag,
    input  mag_evt_t                mag_evt,
    output board_status_t           status,
    output logic [`MB_NUM_AXES-1:0] amp_enable
);
    localparam int AX_W  = $clog2(`MB_NUM_AXES);
    localparam int CNT_W = $clog2(`MB_SAFETY_COUNT + 1);
    localparam logic [CNT_W-1:0] CNT_LIMIT = CNT_W'(`MB_SAFETY_COUNT);

    logic [`MB_NUM_AXES-1:0] en_q;      // amp enable register, chan 0 offset 0
    logic [`MB_NUM_AXES-1:0] dis_q;     // latched safety disables
    logic [CNT_W-1:0]        cnt_q [`MB_NUM_AXES];
    logic                    en_wr;
    logic [AX_W-1:0]         upd_ax;
    logic [`MB_SAMPLE_W+1:0] limit;     // 2 extra bits for 2x + margin
    logic                    over;

    assign en_wr = bus_wr.en && (bus_wr.addr[`MB_ADDR_W-1:8] == '0)
                   && (bus_wr.addr[7:4] == `MB_CHAN_BOARD)
                   && (bus_wr.addr[3:0] == `MB_OFF_ADC_DATA);

    // ----------------------------------------
    // limit check for the axis in the event
    // ----------------------------------------
    assign upd_ax = AX_W'(mag_evt.axis - 3'd1);
    assign limit  = ({2'b00, cmd_mag[upd_ax]} << 1) + {2'b00, `MB_SAFETY_MARGIN};
    assign over   = {2'b00, mag_evt.mag} > limit;  // fb too large for cmd

    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            en_q  <= '0;
            dis_q <= '0;
            for (int i = 0; i < `MB_NUM_AXES; i++)
                cnt_q[i] <= '0;
        end else begin
            if (en_wr)
                en_q <= bus_wr.data[`MB_NUM_AXES-1:0];
            for (int i = 0; i < `MB_NUM_AXES; i++) begin
                if (en_wr && bus_wr.data[i]) begin
                    dis_q[i] <= 1'b0;     // re-enable clears the trip
                    cnt_q[i] <= '0;
                end else if (mag_evt.update && upd_ax == AX_W'(i)) begin
                    if (over) begin
                        if (cnt_q[i] != CNT_LIMIT)
                            cnt_q[i] <= cnt_q[i] + 1'b1;   // saturates
                        if (cnt_q[i] == CNT_LIMIT - 1'b1)
                            dis_q[i] <= 1'b1;              // limit reached
                    end else begin
                        cnt_q[i] <= '0;   // streak broken
                    end
                end
            end
        end
    end

    // ----------------------------------------
    // outputs
    // ----------------------------------------
    assign amp_enable = en_q & ~dis_q;
    assign status     = '{amp_en: amp_enable, safety_dis: dis_q};

endmodule
